// ==== Makefile ====
# Verilator flow for the mips_lite core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module core_tb -f mips_lite.f

sim:
	verilator --binary --timing --assert --top-module core_tb -Mdir obj_dir -f mips_lite.f
	./obj_dir/Vcore_tb 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'hBFC0_0000

// sequential fetch only, no branches
`define CORE_PC_STEP 32'd4

// architectural register count
`define CORE_NUM_REGS 32

`endif

// ==== mips_lite.f ====
+incdir+include
source/mips_isa_pkg.sv
source/core_ctrl_pkg.sv
source/inst_fetch.sv
source/decode_forward.sv
source/register_file.sv
source/alu_execute.sv
source/writeback_port.sv
source/mips_lite_core.sv
verification/core_props.sv
verification/core_tb.sv

// ==== source/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute import mips_isa_pkg::*; import core_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       ex_valid,
    input  word_t      ex_pc,
    input  alu_op_e    ex_op,
    input  src_a_e     ex_src_a,
    input  src_b_e     ex_src_b,
    input  word_t      ex_rs_val,
    input  word_t      ex_rt_val,
    input  word_t      ex_imm,
    input  logic [4:0] ex_shamt,
    input  reg_addr_t  ex_dest,
    input  logic       ex_we,

    output logic       ex_fwd_we,
    output word_t      ex_result,

    output logic       wb_valid,
    output logic       wb_we,
    output reg_addr_t  wb_dest,
    output word_t      wb_pc,
    output word_t      wb_result
);

    word_t op_a;
    word_t op_b;
    word_t alu_out;

    assign op_a = (ex_src_a == SRC_A_SHAMT) ? {27'b0, ex_shamt} : ex_rs_val;
    assign op_b = (ex_src_b == SRC_B_IMM) ? ex_imm : ex_rt_val;

    // shifts move operand b by the low five bits of operand a
    always_comb begin
        case (ex_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_NOR:  alu_out = ~(op_a | op_b);
            ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            ALU_SLL:  alu_out = op_b << op_a[4:0];
            ALU_SRL:  alu_out = op_b >> op_a[4:0];
            ALU_SRA:  alu_out = word_t'($signed(op_b) >>> op_a[4:0]);
            ALU_LUI:  alu_out = {op_b[15:0], 16'b0};
            default:  alu_out = '0;
        endcase
    end

    assign ex_result = alu_out;
    assign ex_fwd_we = ex_valid && ex_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    // held through bubbles, which keeps the last retired pc visible
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_we     <= ex_we;
            wb_dest   <= ex_dest;
            wb_pc     <= ex_pc;
            wb_result <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== source/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // operand a is rs, or shamt for the constant shifts
    typedef enum logic {
        SRC_A_RS,
        SRC_A_SHAMT
    } src_a_e;

    typedef enum logic {
        SRC_B_RT,
        SRC_B_IMM
    } src_b_e;

endpackage

`default_nettype wire

// ==== source/decode_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_forward import mips_isa_pkg::*; import core_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       fetch_valid,
    input  word_t      fetch_instr,
    input  word_t      fetch_pc,

    output reg_addr_t  rs_addr,
    output reg_addr_t  rt_addr,
    input  word_t      rs_rdata,
    input  word_t      rt_rdata,

    input  logic       ex_fwd_we,
    input  reg_addr_t  ex_fwd_dest,
    input  word_t      ex_result,
    input  logic       rf_we,
    input  reg_addr_t  rf_waddr,
    input  word_t      rf_wdata,

    output logic       ex_valid,
    output word_t      ex_pc,
    output alu_op_e    ex_op,
    output src_a_e     ex_src_a,
    output src_b_e     ex_src_b,
    output word_t      ex_rs_val,
    output word_t      ex_rt_val,
    output word_t      ex_imm,
    output logic [4:0] ex_shamt,
    output reg_addr_t  ex_dest,
    output logic       ex_we
);

    logic      id_valid;
    instr_t    id_instr;
    word_t     id_pc;

    alu_op_e   dec_op;
    src_a_e    dec_src_a;
    src_b_e    dec_src_b;
    logic      dec_sign_ext;
    logic      dec_dest_rd;
    logic      dec_known;
    word_t     dec_imm;
    reg_addr_t dec_dest;
    word_t     rs_val;
    word_t     rt_val;

    // EX beats WB beats the register file, r0 never forwarded
    function automatic word_t select_operand(
        input reg_addr_t src,
        input word_t     rf_val,
        input logic      ex_en,
        input reg_addr_t ex_addr,
        input word_t     ex_val,
        input logic      wb_en,
        input reg_addr_t wb_addr,
        input word_t     wb_val
    );
        if (src != '0 && ex_en && ex_addr == src) begin
            return ex_val;
        end
        if (src != '0 && wb_en && wb_addr == src) begin
            return wb_val;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            id_instr <= fetch_instr;
            id_pc    <= fetch_pc;
        end
    end

    always_comb begin
        dec_op       = ALU_ADD;
        dec_src_a    = SRC_A_RS;
        dec_src_b    = SRC_B_IMM;
        dec_sign_ext = 1'b0;
        dec_dest_rd  = 1'b0;
        dec_known    = 1'b1;
        case (id_instr.r_fmt.opcode)
            OP_SPECIAL: begin
                dec_src_b   = SRC_B_RT;
                dec_dest_rd = 1'b1;
                case (id_instr.r_fmt.funct)
                    FN_ADDU: dec_op = ALU_ADD;
                    FN_SUBU: dec_op = ALU_SUB;
                    FN_AND:  dec_op = ALU_AND;
                    FN_OR:   dec_op = ALU_OR;
                    FN_XOR:  dec_op = ALU_XOR;
                    FN_NOR:  dec_op = ALU_NOR;
                    FN_SLT:  dec_op = ALU_SLT;
                    FN_SLTU: dec_op = ALU_SLTU;
                    FN_SLL: begin
                        dec_op    = ALU_SLL;
                        dec_src_a = SRC_A_SHAMT;
                    end
                    FN_SRL: begin
                        dec_op    = ALU_SRL;
                        dec_src_a = SRC_A_SHAMT;
                    end
                    FN_SRA: begin
                        dec_op    = ALU_SRA;
                        dec_src_a = SRC_A_SHAMT;
                    end
                    default: dec_known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                dec_op       = ALU_ADD;
                dec_sign_ext = 1'b1;
            end
            OP_SLTI: begin
                dec_op       = ALU_SLT;
                dec_sign_ext = 1'b1;
            end
            OP_SLTIU: begin
                // sign-extended, then compared unsigned
                dec_op       = ALU_SLTU;
                dec_sign_ext = 1'b1;
            end
            OP_ANDI: dec_op = ALU_AND;
            OP_ORI:  dec_op = ALU_OR;
            OP_XORI: dec_op = ALU_XOR;
            OP_LUI:  dec_op = ALU_LUI;
            default: dec_known = 1'b0;
        endcase
    end

    assign dec_imm = dec_sign_ext ? {{16{id_instr.i_fmt.imm[15]}}, id_instr.i_fmt.imm}
                                  : {16'b0, id_instr.i_fmt.imm};
    assign dec_dest = dec_dest_rd ? id_instr.r_fmt.rd : id_instr.i_fmt.rt;

    assign rs_addr = id_instr.r_fmt.rs;
    assign rt_addr = id_instr.r_fmt.rt;

    assign rs_val = select_operand(rs_addr, rs_rdata, ex_fwd_we, ex_fwd_dest, ex_result,
                                   rf_we, rf_waddr, rf_wdata);
    assign rt_val = select_operand(rt_addr, rt_rdata, ex_fwd_we, ex_fwd_dest, ex_result,
                                   rf_we, rf_waddr, rf_wdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_pc     <= id_pc;
            ex_op     <= dec_op;
            ex_src_a  <= dec_src_a;
            ex_src_b  <= dec_src_b;
            ex_rs_val <= rs_val;
            ex_rt_val <= rt_val;
            ex_imm    <= dec_imm;
            ex_shamt  <= id_instr.r_fmt.shamt;
            ex_dest   <= dec_dest;
            ex_we     <= dec_known && (dec_dest != '0);
        end
    end

endmodule

`default_nettype wire

// ==== source/inst_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module inst_fetch import mips_isa_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    output logic  inst_sram_req,
    output word_t inst_sram_addr,
    input  logic  inst_sram_addr_ok,
    input  logic  inst_sram_data_ok,
    input  word_t inst_sram_rdata,

    output logic  fetch_valid,
    output word_t fetch_instr,
    output word_t fetch_pc
);

    localparam logic S_REQ  = 1'b0;
    localparam logic S_WAIT = 1'b1;

    logic  state;
    logic  req;
    word_t pc;
    word_t req_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_REQ;
            req   <= 1'b0;
            pc    <= `CORE_RESET_PC;
        end else if (state == S_REQ) begin
            if (req && inst_sram_addr_ok) begin
                // address taken, wait for the word
                state <= S_WAIT;
                req   <= 1'b0;
                pc    <= pc + `CORE_PC_STEP;
            end else begin
                req <= 1'b1;
            end
        end else if (inst_sram_data_ok) begin
            state <= S_REQ;
            req   <= 1'b1;
        end
    end

    // pc of the outstanding request, paired with the returned word
    always_ff @(posedge clk) begin
        if (req && inst_sram_addr_ok) begin
            req_pc <= pc;
        end
    end

    assign inst_sram_req  = req;
    assign inst_sram_addr = pc;

    // only one request in flight, so data_ok belongs to req_pc
    assign fetch_valid = inst_sram_data_ok && (state == S_WAIT);
    assign fetch_instr = inst_sram_rdata;
    assign fetch_pc    = req_pc;

endmodule

`default_nettype wire

// ==== source/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcodes that the core executes
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // one word, two views
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            logic [15:0] imm;
        } i_fmt;
    } instr_t;

endpackage

`default_nettype wire

// ==== source/mips_lite_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_lite_core import mips_isa_pkg::*; import core_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    output logic       inst_sram_req,
    output word_t      inst_sram_addr,
    input  logic       inst_sram_addr_ok,
    input  logic       inst_sram_data_ok,
    input  word_t      inst_sram_rdata,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic       fetch_valid;
    word_t      fetch_instr;
    word_t      fetch_pc;

    reg_addr_t  rs_addr;
    reg_addr_t  rt_addr;
    word_t      rs_rdata;
    word_t      rt_rdata;

    logic       ex_valid;
    word_t      ex_pc;
    alu_op_e    ex_op;
    src_a_e     ex_src_a;
    src_b_e     ex_src_b;
    word_t      ex_rs_val;
    word_t      ex_rt_val;
    word_t      ex_imm;
    logic [4:0] ex_shamt;
    reg_addr_t  ex_dest;
    logic       ex_we;
    logic       ex_fwd_we;
    word_t      ex_result;

    logic       wb_valid;
    logic       wb_we;
    reg_addr_t  wb_dest;
    word_t      wb_pc;
    word_t      wb_result;

    logic       rf_we;
    reg_addr_t  rf_waddr;
    word_t      rf_wdata;

    inst_fetch inst_fetch_inst (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .fetch_valid       (fetch_valid),
        .fetch_instr       (fetch_instr),
        .fetch_pc          (fetch_pc)
    );

    decode_forward decode_forward_inst (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_pc    (fetch_pc),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_rdata    (rs_rdata),
        .rt_rdata    (rt_rdata),
        .ex_fwd_we   (ex_fwd_we),
        .ex_fwd_dest (ex_dest),
        .ex_result   (ex_result),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_op       (ex_op),
        .ex_src_a    (ex_src_a),
        .ex_src_b    (ex_src_b),
        .ex_rs_val   (ex_rs_val),
        .ex_rt_val   (ex_rt_val),
        .ex_imm      (ex_imm),
        .ex_shamt    (ex_shamt),
        .ex_dest     (ex_dest),
        .ex_we       (ex_we)
    );

    register_file register_file_inst (
        .clk (clk),
        .ra1 (rs_addr),
        .ra2 (rt_addr),
        .rd1 (rs_rdata),
        .rd2 (rt_rdata),
        .we  (rf_we),
        .wa  (rf_waddr),
        .wd  (rf_wdata)
    );

    alu_execute alu_execute_inst (
        .clk       (clk),
        .reset     (reset),
        .ex_valid  (ex_valid),
        .ex_pc     (ex_pc),
        .ex_op     (ex_op),
        .ex_src_a  (ex_src_a),
        .ex_src_b  (ex_src_b),
        .ex_rs_val (ex_rs_val),
        .ex_rt_val (ex_rt_val),
        .ex_imm    (ex_imm),
        .ex_shamt  (ex_shamt),
        .ex_dest   (ex_dest),
        .ex_we     (ex_we),
        .ex_fwd_we (ex_fwd_we),
        .ex_result (ex_result),
        .wb_valid  (wb_valid),
        .wb_we     (wb_we),
        .wb_dest   (wb_dest),
        .wb_pc     (wb_pc),
        .wb_result (wb_result)
    );

    writeback_port writeback_port_inst (
        .wb_valid          (wb_valid),
        .wb_we             (wb_we),
        .wb_dest           (wb_dest),
        .wb_pc             (wb_pc),
        .wb_result         (wb_result),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module register_file import mips_isa_pkg::*; (
    input  logic      clk,

    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    output word_t     rd1,
    output word_t     rd2,

    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd
);

    word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // r0 is hardwired
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== source/writeback_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_port import mips_isa_pkg::*; (
    input  logic       wb_valid,
    input  logic       wb_we,
    input  reg_addr_t  wb_dest,
    input  word_t      wb_pc,
    input  word_t      wb_result,

    output logic       rf_we,
    output reg_addr_t  rf_waddr,
    output word_t      rf_wdata,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic retire_we;

    // one qualifier for regfile, forwarding and debug
    assign retire_we = wb_valid && wb_we;

    assign rf_we    = retire_we;
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_result;

    // wb_pc only updates on valid beats
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{retire_we}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_result;

endmodule

`default_nettype wire

// ==== verification/core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_props import mips_isa_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       inst_sram_req,
    input word_t      inst_sram_addr,
    input logic       inst_sram_addr_ok,
    input logic       inst_sram_data_ok,
    input logic [3:0] debug_wb_rf_wen
);

    logic  accept;
    logic  outstanding;
    logic  seen_accept;
    word_t last_addr;

    assign accept = inst_sram_req && inst_sram_addr_ok;

    // tracks the single request in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
            seen_accept <= 1'b0;
        end else if (accept) begin
            outstanding <= 1'b1;
            seen_accept <= 1'b1;
            last_addr   <= inst_sram_addr;
        end else if (inst_sram_data_ok) begin
            outstanding <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (reset)
        inst_sram_req && !inst_sram_addr_ok |=> inst_sram_req && $stable(inst_sram_addr))
        else $error("inst_sram_req dropped or inst_sram_addr moved before addr_ok");

    one_in_flight: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !accept)
        else $error("second fetch accepted before data_ok");

    addr_step: assert property (@(posedge clk) disable iff (reset)
        accept && seen_accept |-> inst_sram_addr == last_addr + `CORE_PC_STEP)
        else $error("accepted fetch address did not step by one word");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !inst_sram_req && debug_wb_rf_wen == 4'b0)
        else $error("request or debug write active during reset");

endmodule

bind mips_lite_core core_props core_props_inst (
    .clk               (clk),
    .reset             (reset),
    .inst_sram_req     (inst_sram_req),
    .inst_sram_addr    (inst_sram_addr),
    .inst_sram_addr_ok (inst_sram_addr_ok),
    .inst_sram_data_ok (inst_sram_data_ok),
    .debug_wb_rf_wen   (debug_wb_rf_wen)
);

`default_nettype wire

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_tb import mips_isa_pkg::*; ();

    localparam int PROG_LEN       = 256;
    localparam int PREFIX_LEN     = 47;
    localparam int RETIRE_GOAL    = 200;
    localparam int RETIRE_TIMEOUT = 400;
    localparam int ACCEPT_TIMEOUT = 50;

    localparam logic [5:0] R_FUNCTS [11] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND,
        FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU
    };
    localparam logic [5:0] I_OPCODES [7] = '{
        OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
    };

    logic       clk               = 1'b0;
    logic       reset             = 1'b1;
    logic       inst_sram_addr_ok = 1'b0;
    logic       inst_sram_data_ok = 1'b0;
    word_t      inst_sram_rdata   = '0;
    logic       inst_sram_req;
    word_t      inst_sram_addr;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    integer     seed = 99911;
    word_t      program_mem [PROG_LEN];
    word_t      model_regs [`CORE_NUM_REGS];
    word_t      seen_regs [`CORE_NUM_REGS];
    word_t      model_pc;
    int         model_idx;

    // memory responder state
    int         accept_count = 0;
    logic       pending      = 1'b0;
    int         pend_cnt     = 0;
    word_t      pend_addr;

    always #50 clk = ~clk;

    mips_lite_core mips_lite_core_inst (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failing check");
    endtask

    function automatic word_t make_r(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] shamt,
                                     input logic [5:0] funct);
        instr_t ins;
        ins.r_fmt.opcode = OP_SPECIAL;
        ins.r_fmt.rs     = rs;
        ins.r_fmt.rt     = rt;
        ins.r_fmt.rd     = rd;
        ins.r_fmt.shamt  = shamt;
        ins.r_fmt.funct  = funct;
        return ins;
    endfunction

    function automatic word_t make_i(input logic [5:0] opcode, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        instr_t ins;
        ins.i_fmt.opcode = opcode;
        ins.i_fmt.rs     = rs;
        ins.i_fmt.rt     = rt;
        ins.i_fmt.imm    = imm;
        return ins;
    endfunction

    // three picks in four land in r0..r7
    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[1:0] != 2'b00) begin
            return {2'b00, r[4:2]};
        end
        return r[9:5];
    endfunction

    function automatic word_t random_instr();
        logic [31:0] r;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        int          kind;
        r    = $random(seed);
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        kind = int'(r[7:0]) % 20;
        if (kind < 11) begin
            return make_r(rs, rt, rd, r[12:8], R_FUNCTS[kind]);
        end
        if (kind < 18) begin
            return make_i(I_OPCODES[kind - 11], rs, rt, r[31:16]);
        end
        // lw and mult encodings that the core does not execute
        if (kind == 18) begin
            return make_i(6'h23, rs, rt, r[31:16]);
        end
        return make_r(rs, rt, rd, 5'd0, 6'h18);
    endfunction

    // reference semantics of the supported subset
    function automatic logic execute_model(input word_t w, output reg_addr_t dest,
                                           output word_t val);
        instr_t ins;
        word_t  a;
        word_t  b;
        word_t  sext;
        word_t  zext;
        logic   known;
        ins   = w;
        a     = model_regs[ins.r_fmt.rs];
        b     = model_regs[ins.r_fmt.rt];
        sext  = {{16{ins.i_fmt.imm[15]}}, ins.i_fmt.imm};
        zext  = {16'h0, ins.i_fmt.imm};
        known = 1'b1;
        dest  = ins.i_fmt.rt;
        val   = '0;
        case (ins.r_fmt.opcode)
            OP_SPECIAL: begin
                dest = ins.r_fmt.rd;
                case (ins.r_fmt.funct)
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    FN_NOR:  val = ~(a | b);
                    FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  val = b << ins.r_fmt.shamt;
                    FN_SRL:  val = b >> ins.r_fmt.shamt;
                    FN_SRA:  val = word_t'($signed(b) >>> ins.r_fmt.shamt);
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: val = a + sext;
            OP_SLTI:  val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_SLTIU: val = (a < sext) ? 32'd1 : 32'd0;
            OP_ANDI:  val = a & zext;
            OP_ORI:   val = a | zext;
            OP_XORI:  val = a ^ zext;
            OP_LUI:   val = {ins.i_fmt.imm, 16'h0};
            default:  known = 1'b0;
        endcase
        return known && (dest != '0);
    endfunction

    // seeds all registers, then dependent addiu/addu pairs, then random code
    task automatic build_program();
        logic [31:0] r;
        reg_addr_t   a;
        reg_addr_t   b;
        for (int i = 1; i < `CORE_NUM_REGS; i++) begin
            r = $random(seed);
            program_mem[i - 1] = make_i(OP_ADDIU, 5'd0, reg_addr_t'(i), r[15:0]);
        end
        for (int j = 0; j < 8; j++) begin
            r = $random(seed);
            a = reg_addr_t'(j % 7 + 1);
            b = reg_addr_t'((j + 1) % 7 + 1);
            program_mem[31 + 2 * j] = make_i(OP_ADDIU, a, a, r[15:0]);
            program_mem[32 + 2 * j] = make_r(a, b, b, 5'd0, FN_ADDU);
        end
        for (int i = PREFIX_LEN; i < PROG_LEN; i++) begin
            program_mem[i] = random_instr();
        end
    endtask

    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        offset = (addr - `CORE_RESET_PC) >> 2;
        // past the program the core runs on nops
        if (offset < PROG_LEN) begin
            return program_mem[offset[7:0]];
        end
        return '0;
    endfunction

    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        if (reset) begin
            inst_sram_addr_ok <= 1'b0;
            inst_sram_data_ok <= 1'b0;
            pending = 1'b0;
        end else begin
            inst_sram_data_ok <= 1'b0;
            if (inst_sram_req && inst_sram_addr_ok) begin
                if (accept_count == 0) begin
                    assert (inst_sram_addr == `CORE_RESET_PC) else begin
                        $display("ERR %0t inst_sram_addr got %h exp %h",
                                 $time, inst_sram_addr, `CORE_RESET_PC);
                        abort_run();
                    end
                end
                pending   = 1'b1;
                pend_addr = inst_sram_addr;
                pend_cnt  = (accept_count < PREFIX_LEN) ? 1 : 1 + int'(rnd[3:2]);
                accept_count++;
            end
            if (pending) begin
                if (pend_cnt == 1) begin
                    inst_sram_data_ok <= 1'b1;
                    inst_sram_rdata   <= fetch_word(pend_addr);
                    pending = 1'b0;
                end else begin
                    pend_cnt--;
                end
            end
            // minimum latency while the directed prefix runs
            inst_sram_addr_ok <= (accept_count < PREFIX_LEN) || rnd[0] || rnd[1];
        end
    end

    task automatic check_retirement();
        reg_addr_t exp_dest;
        word_t     exp_val;
        word_t     exp_pc;
        logic      found;
        found = 1'b0;
        while (!found && model_idx < PROG_LEN) begin
            exp_pc = model_pc;
            found  = execute_model(program_mem[model_idx], exp_dest, exp_val);
            model_pc = model_pc + `CORE_PC_STEP;
            model_idx++;
        end
        assert (found) else begin
            $display("register write retired after the program had no writes left");
            abort_run();
        end
        assert (debug_wb_rf_wen == 4'hf) else begin
            $display("ERR %0t debug_wb_rf_wen got %h exp f", $time, debug_wb_rf_wen);
            abort_run();
        end
        assert (debug_wb_pc == exp_pc) else begin
            $display("ERR %0t debug_wb_pc got %h exp %h", $time, debug_wb_pc, exp_pc);
            abort_run();
        end
        assert (debug_wb_rf_wnum == exp_dest) else begin
            $display("ERR %0t debug_wb_rf_wnum got %0d exp %0d",
                     $time, debug_wb_rf_wnum, exp_dest);
            abort_run();
        end
        assert (debug_wb_rf_wdata == exp_val) else begin
            $display("ERR %0t debug_wb_rf_wdata got %h exp %h",
                     $time, debug_wb_rf_wdata, exp_val);
            abort_run();
        end
        model_regs[exp_dest]        = exp_val;
        seen_regs[debug_wb_rf_wnum] = debug_wb_rf_wdata;
    endtask

    initial begin
        int        cycles;
        int        idle;
        int        retired;
        int        total_writers;
        int        target;
        reg_addr_t scratch_dest;
        word_t     scratch_val;

        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            model_regs[i] = '0;
            seen_regs[i]  = '0;
        end
        model_pc  = `CORE_RESET_PC;
        model_idx = 0;
        build_program();

        // write count depends on the encoding only
        total_writers = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (execute_model(program_mem[i], scratch_dest, scratch_val)) begin
                total_writers++;
            end
        end
        target = (total_writers < RETIRE_GOAL) ? total_writers : RETIRE_GOAL;

        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            assert (inst_sram_req == 1'b0) else begin
                $display("ERR %0t inst_sram_req got %b exp 0", $time, inst_sram_req);
                abort_run();
            end
            assert (debug_wb_rf_wen == 4'b0) else begin
                $display("ERR %0t debug_wb_rf_wen got %h exp 0", $time, debug_wb_rf_wen);
                abort_run();
            end
        end

        cycles = 0;
        while (accept_count == 0) begin
            @(negedge clk);
            cycles++;
            assert (cycles < ACCEPT_TIMEOUT) else begin
                $display("timeout waiting for the first fetch to be accepted");
                abort_run();
            end
        end

        retired = 0;
        idle    = 0;
        while (retired < target) begin
            @(negedge clk);
            if (debug_wb_rf_wen != 4'b0) begin
                check_retirement();
                retired++;
                idle = 0;
            end else begin
                idle++;
                assert (idle < RETIRE_TIMEOUT) else begin
                    $display("timeout: no register write retired for %0d cycles", idle);
                    abort_run();
                end
            end
        end

        for (int i = 1; i < `CORE_NUM_REGS; i++) begin
            assert (seen_regs[i] == model_regs[i]) else begin
                $display("ERR %0t debug_wb_rf_wdata for r%0d got %h exp %h",
                         $time, i, seen_regs[i], model_regs[i]);
                abort_run();
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
